// ==== common/plat_ctrl_pkg.sv ====
`default_nettype none

package plat_ctrl_pkg;

	// ******************************************************************
	// Data types
	// ******************************************************************

	// Bus data word
	typedef logic [31:0] word_t;

	// Byte address inside the controller
	typedef logic [7:0] addr_t;

	// Boot mode pins
	typedef logic [1:0] boot_mode_t;

	// Core finish count, wraps on overflow
	typedef logic [7:0] count_t;

	// Boot progress as seen by software
	typedef enum logic [1:0]
	{
		BOOT_RESETED   = 2'd0,
		BOOT_APP_LOAD  = 2'd1,
		BOOT_ALL_READY = 2'd2
	} boot_status_t;

	// ******************************************************************
	// Core counts
	// ******************************************************************

	localparam int NUM_CORES = 2;
	localparam int MAX_CORE_SLOTS = 4;

	// Each core reports twice before the system counts as done
	localparam count_t DONE_TARGET = count_t'(2 * NUM_CORES);

	// ******************************************************************
	// Register map
	// ******************************************************************

	localparam addr_t REG_BOOT_MODE    = 8'h00;
	localparam addr_t REG_BOOT_STATUS  = 8'h04;
	localparam addr_t REG_APP_LOADED   = 8'h08;
	localparam addr_t REG_ALL_READY    = 8'h0C;
	localparam addr_t REG_CORE_DONE    = 8'h10;
	localparam addr_t REG_FINISH_COUNT = 8'h14;
	localparam addr_t REG_HALT         = 8'h18;

	// Program counter slot i sits at base + 4*i
	localparam addr_t REG_CORE_PC_BASE = 8'h20;

	// Read value of slots with no core behind them
	localparam word_t PC_UNUSED = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== files.f ====
common/plat_ctrl_pkg.sv
plat_ctrl/port_merger.sv
plat_ctrl/plat_regs.sv
plat_ctrl/boot_tracker.sv
hw/plat_ctrl_top.sv
tb/plat_ctrl_tb.sv

// ==== hw/plat_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module plat_ctrl_top
(
	input  wire                                                rvx_port_19,
	input  wire                                                rvx_port_18,

	input  wire                                                i_p0_sel,
	input  wire                                                i_p0_enable,
	input  plat_ctrl_pkg::addr_t                               i_p0_addr,
	input  wire                                                i_p0_write,
	input  plat_ctrl_pkg::word_t                               i_p0_wdata,
	output plat_ctrl_pkg::word_t                               o_p0_rdata,
	output logic                                               o_p0_ready,
	output logic                                               o_p0_slverr,

	input  wire                                                i_p1_sel,
	input  wire                                                i_p1_enable,
	input  plat_ctrl_pkg::addr_t                               i_p1_addr,
	input  wire                                                i_p1_write,
	input  plat_ctrl_pkg::word_t                               i_p1_wdata,
	output plat_ctrl_pkg::word_t                               o_p1_rdata,
	output logic                                               o_p1_ready,
	output logic                                               o_p1_slverr,

	input  plat_ctrl_pkg::boot_mode_t                          i_boot_mode,
	input  plat_ctrl_pkg::word_t [plat_ctrl_pkg::NUM_CORES-1:0] i_core_pc,
	output logic                                               o_all_done
);

	// Merger to register block
	logic m_valid;
	plat_ctrl_pkg::addr_t m_addr;
	logic m_write;
	plat_ctrl_pkg::word_t m_wdata;
	plat_ctrl_pkg::word_t r_rdata;
	logic r_slverr;

	// Register block to tracker
	logic app_loaded_pulse;
	logic all_ready_pulse;
	logic core_done_pulse;
	logic halt_pulse;
	plat_ctrl_pkg::boot_mode_t boot_mode;
	plat_ctrl_pkg::boot_status_t boot_status;
	plat_ctrl_pkg::count_t finish_count;
	logic halt_flag;
	plat_ctrl_pkg::word_t [plat_ctrl_pkg::MAX_CORE_SLOTS-1:0] core_pc;

	port_merger u_port_merger
	(
		.i_clk       (rvx_port_19),
		.i_rstn      (rvx_port_18),
		.i_p0_sel    (i_p0_sel),
		.i_p0_enable (i_p0_enable),
		.i_p0_addr   (i_p0_addr),
		.i_p0_write  (i_p0_write),
		.i_p0_wdata  (i_p0_wdata),
		.o_p0_rdata  (o_p0_rdata),
		.o_p0_ready  (o_p0_ready),
		.o_p0_slverr (o_p0_slverr),
		.i_p1_sel    (i_p1_sel),
		.i_p1_enable (i_p1_enable),
		.i_p1_addr   (i_p1_addr),
		.i_p1_write  (i_p1_write),
		.i_p1_wdata  (i_p1_wdata),
		.o_p1_rdata  (o_p1_rdata),
		.o_p1_ready  (o_p1_ready),
		.o_p1_slverr (o_p1_slverr),
		.o_m_valid   (m_valid),
		.o_m_addr    (m_addr),
		.o_m_write   (m_write),
		.o_m_wdata   (m_wdata),
		.i_r_rdata   (r_rdata),
		.i_r_slverr  (r_slverr)
	);

	plat_regs u_plat_regs
	(
		.i_clk              (rvx_port_19),
		.i_rstn             (rvx_port_18),
		.i_m_valid          (m_valid),
		.i_m_addr           (m_addr),
		.i_m_write          (m_write),
		.i_m_wdata          (m_wdata),
		.o_r_rdata          (r_rdata),
		.o_r_slverr         (r_slverr),
		.o_app_loaded_pulse (app_loaded_pulse),
		.o_all_ready_pulse  (all_ready_pulse),
		.o_core_done_pulse  (core_done_pulse),
		.o_halt_pulse       (halt_pulse),
		.i_boot_mode        (boot_mode),
		.i_boot_status      (boot_status),
		.i_finish_count     (finish_count),
		.i_halt_flag        (halt_flag),
		.i_core_pc          (core_pc)
	);

	boot_tracker u_boot_tracker
	(
		.i_clk              (rvx_port_19),
		.i_rstn             (rvx_port_18),
		.i_boot_mode_async  (i_boot_mode),
		.i_core_pc_async    (i_core_pc),
		.i_app_loaded_pulse (app_loaded_pulse),
		.i_all_ready_pulse  (all_ready_pulse),
		.i_core_done_pulse  (core_done_pulse),
		.i_halt_pulse       (halt_pulse),
		.o_boot_mode        (boot_mode),
		.o_boot_status      (boot_status),
		.o_finish_count     (finish_count),
		.o_halt_flag        (halt_flag),
		.o_core_pc          (core_pc),
		.o_all_done         (o_all_done)
	);

endmodule

`default_nettype wire

// ==== plat_ctrl/boot_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module boot_tracker
(
	input  wire                                                i_clk,
	input  wire                                                i_rstn,

	input  plat_ctrl_pkg::boot_mode_t                          i_boot_mode_async,
	input  plat_ctrl_pkg::word_t [plat_ctrl_pkg::NUM_CORES-1:0] i_core_pc_async,

	input  wire                                                i_app_loaded_pulse,
	input  wire                                                i_all_ready_pulse,
	input  wire                                                i_core_done_pulse,
	input  wire                                                i_halt_pulse,

	output plat_ctrl_pkg::boot_mode_t                          o_boot_mode,
	output plat_ctrl_pkg::boot_status_t                        o_boot_status,
	output plat_ctrl_pkg::count_t                              o_finish_count,
	output logic                                               o_halt_flag,
	output plat_ctrl_pkg::word_t [plat_ctrl_pkg::MAX_CORE_SLOTS-1:0] o_core_pc,
	output logic                                               o_all_done
);

	plat_ctrl_pkg::boot_mode_t mode_meta;
	plat_ctrl_pkg::word_t [plat_ctrl_pkg::NUM_CORES-1:0] pc_meta;
	plat_ctrl_pkg::word_t [plat_ctrl_pkg::NUM_CORES-1:0] pc_sync;

	// Two-flop synchronizers for the pins and program counters
	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			mode_meta   <= '0;
			o_boot_mode <= '0;
			pc_meta     <= '0;
			pc_sync     <= '0;
		end
		else
		begin
			mode_meta   <= i_boot_mode_async;
			o_boot_mode <= mode_meta;
			pc_meta     <= i_core_pc_async;
			pc_sync     <= pc_meta;
		end
	end

	// Slots past the last core read as all ones
	for (genvar i = 0; i < plat_ctrl_pkg::MAX_CORE_SLOTS; i++)
	begin : g_pc_slot
		if (i < plat_ctrl_pkg::NUM_CORES)
		begin : g_used
			assign o_core_pc[i] = pc_sync[i];
		end
		else
		begin : g_unused
			assign o_core_pc[i] = plat_ctrl_pkg::PC_UNUSED;
		end
	end

	// ******************************************************************
	// Boot status, finish count and halt request
	// ******************************************************************

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			o_boot_status  <= plat_ctrl_pkg::BOOT_RESETED;
			o_finish_count <= '0;
			o_halt_flag    <= 1'b0;
		end
		else
		begin
			case (o_boot_status)
				plat_ctrl_pkg::BOOT_RESETED:
					if (i_app_loaded_pulse)
						o_boot_status <= plat_ctrl_pkg::BOOT_APP_LOAD;
				plat_ctrl_pkg::BOOT_APP_LOAD:
					if (i_all_ready_pulse)
						o_boot_status <= plat_ctrl_pkg::BOOT_ALL_READY;
				// ALL_READY holds until reset
				default:
					o_boot_status <= o_boot_status;
			endcase
			if (i_core_done_pulse)
				o_finish_count <= o_finish_count + 1'b1;
			if (i_halt_pulse)
				o_halt_flag <= 1'b1;
		end
	end

	assign o_all_done = (o_finish_count == plat_ctrl_pkg::DONE_TARGET);

endmodule

`default_nettype wire

// ==== plat_ctrl/plat_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module plat_regs
(
	input  wire                                                i_clk,
	input  wire                                                i_rstn,

	input  wire                                                i_m_valid,
	input  plat_ctrl_pkg::addr_t                               i_m_addr,
	input  wire                                                i_m_write,
	input  plat_ctrl_pkg::word_t                               i_m_wdata,
	output plat_ctrl_pkg::word_t                               o_r_rdata,
	output logic                                               o_r_slverr,

	output logic                                               o_app_loaded_pulse,
	output logic                                               o_all_ready_pulse,
	output logic                                               o_core_done_pulse,
	output logic                                               o_halt_pulse,

	input  plat_ctrl_pkg::boot_mode_t                          i_boot_mode,
	input  plat_ctrl_pkg::boot_status_t                        i_boot_status,
	input  plat_ctrl_pkg::count_t                              i_finish_count,
	input  wire                                                i_halt_flag,
	input  plat_ctrl_pkg::word_t [plat_ctrl_pkg::MAX_CORE_SLOTS-1:0] i_core_pc
);

	plat_ctrl_pkg::word_t rd_value;
	plat_ctrl_pkg::addr_t pc_offset;
	logic mapped;
	logic is_ro;
	logic is_event;
	logic is_pc;
	logic wr_ok;

	assign pc_offset = i_m_addr - plat_ctrl_pkg::REG_CORE_PC_BASE;
	assign is_pc = (i_m_addr >= plat_ctrl_pkg::REG_CORE_PC_BASE) &&
		(pc_offset < plat_ctrl_pkg::addr_t'(4 * plat_ctrl_pkg::MAX_CORE_SLOTS)) &&
		(i_m_addr[1:0] == 2'b00);

	// ******************************************************************
	// Address decode
	// ******************************************************************

	always_comb
	begin
		rd_value = '0;
		mapped   = 1'b1;
		is_ro    = 1'b0;
		is_event = 1'b0;
		case (i_m_addr)
			plat_ctrl_pkg::REG_BOOT_MODE:
			begin
				rd_value = plat_ctrl_pkg::word_t'(i_boot_mode);
				is_ro    = 1'b1;
			end
			plat_ctrl_pkg::REG_BOOT_STATUS:
			begin
				rd_value = plat_ctrl_pkg::word_t'(i_boot_status);
				is_ro    = 1'b1;
			end
			plat_ctrl_pkg::REG_APP_LOADED,
			plat_ctrl_pkg::REG_ALL_READY,
			plat_ctrl_pkg::REG_CORE_DONE:
				is_event = 1'b1;
			plat_ctrl_pkg::REG_FINISH_COUNT:
			begin
				rd_value = plat_ctrl_pkg::word_t'(i_finish_count);
				is_ro    = 1'b1;
			end
			// Halt is writable and readable
			plat_ctrl_pkg::REG_HALT:
				rd_value = plat_ctrl_pkg::word_t'(i_halt_flag);
			default:
				if (is_pc)
				begin
					rd_value = i_core_pc[pc_offset[$clog2(plat_ctrl_pkg::MAX_CORE_SLOTS)+1:2]];
					is_ro    = 1'b1;
				end
				else
					mapped = 1'b0;
		endcase
	end

	// Error response and read data for the access in flight
	assign o_r_slverr = i_m_valid &&
		(!mapped || (i_m_write && is_ro) || (!i_m_write && is_event));
	assign o_r_rdata = (i_m_valid && !i_m_write && !o_r_slverr) ? rd_value : '0;

	// ******************************************************************
	// Write events
	// ******************************************************************

	// Write data carries no meaning, only the strobe counts
	assign wr_ok = i_m_valid && i_m_write;

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
		begin
			o_app_loaded_pulse <= 1'b0;
			o_all_ready_pulse  <= 1'b0;
			o_core_done_pulse  <= 1'b0;
			o_halt_pulse       <= 1'b0;
		end
		else
		begin
			o_app_loaded_pulse <= wr_ok && (i_m_addr == plat_ctrl_pkg::REG_APP_LOADED);
			o_all_ready_pulse  <= wr_ok && (i_m_addr == plat_ctrl_pkg::REG_ALL_READY);
			o_core_done_pulse  <= wr_ok && (i_m_addr == plat_ctrl_pkg::REG_CORE_DONE);
			o_halt_pulse       <= wr_ok && (i_m_addr == plat_ctrl_pkg::REG_HALT);
		end
	end

endmodule

`default_nettype wire

// ==== plat_ctrl/port_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_merger
(
	input  wire                        i_clk,
	input  wire                        i_rstn,

	input  wire                        i_p0_sel,
	input  wire                        i_p0_enable,
	input  plat_ctrl_pkg::addr_t       i_p0_addr,
	input  wire                        i_p0_write,
	input  plat_ctrl_pkg::word_t       i_p0_wdata,
	output plat_ctrl_pkg::word_t       o_p0_rdata,
	output logic                       o_p0_ready,
	output logic                       o_p0_slverr,

	input  wire                        i_p1_sel,
	input  wire                        i_p1_enable,
	input  plat_ctrl_pkg::addr_t       i_p1_addr,
	input  wire                        i_p1_write,
	input  plat_ctrl_pkg::word_t       i_p1_wdata,
	output plat_ctrl_pkg::word_t       o_p1_rdata,
	output logic                       o_p1_ready,
	output logic                       o_p1_slverr,

	output logic                       o_m_valid,
	output plat_ctrl_pkg::addr_t       o_m_addr,
	output logic                       o_m_write,
	output plat_ctrl_pkg::word_t       o_m_wdata,
	input  plat_ctrl_pkg::word_t       i_r_rdata,
	input  wire                        i_r_slverr
);

	typedef enum logic [1:0] {OWN_IDLE, OWN_P0, OWN_P1} owner_t;

	owner_t owner_q;
	owner_t owner_d;
	logic p0_access;
	logic p1_access;

	// Access phase of the port that holds the grant
	assign p0_access = (owner_q == OWN_P0) && i_p0_sel && i_p0_enable;
	assign p1_access = (owner_q == OWN_P1) && i_p1_sel && i_p1_enable;

	assign o_m_valid = p0_access || p1_access;
	assign o_m_addr  = (owner_q == OWN_P1) ? i_p1_addr  : i_p0_addr;
	assign o_m_write = (owner_q == OWN_P1) ? i_p1_write : i_p0_write;
	assign o_m_wdata = (owner_q == OWN_P1) ? i_p1_wdata : i_p0_wdata;

	// Register block answers in the same cycle, so ready follows the access
	assign o_p0_ready  = p0_access;
	assign o_p0_rdata  = p0_access ? i_r_rdata : '0;
	assign o_p0_slverr = p0_access && i_r_slverr;

	assign o_p1_ready  = p1_access;
	assign o_p1_rdata  = p1_access ? i_r_rdata : '0;
	assign o_p1_slverr = p1_access && i_r_slverr;

	// Fixed priority to port 0; a waiting port takes over on completion
	always_comb
	begin
		owner_d = owner_q;
		case (owner_q)
			OWN_IDLE:
				if (i_p0_sel)
					owner_d = OWN_P0;
				else if (i_p1_sel)
					owner_d = OWN_P1;
			OWN_P0:
				if (p0_access || !i_p0_sel)
					owner_d = i_p1_sel ? OWN_P1 : OWN_IDLE;
			OWN_P1:
				if (p1_access || !i_p1_sel)
					owner_d = i_p0_sel ? OWN_P0 : OWN_IDLE;
			default:
				owner_d = OWN_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rstn)
	begin
		if (!i_rstn)
			owner_q <= OWN_IDLE;
		else
			owner_q <= owner_d;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the platform controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module plat_ctrl_tb -f files.f -o plat_ctrl_sim

out=$(./obj_dir/plat_ctrl_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='
then
	exit 0
fi
exit 1

// ==== tb/plat_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module plat_ctrl_tb;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int WAIT_LIMIT = 20;
	localparam int DONE_COUNT = 2 * plat_ctrl_pkg::NUM_CORES;

	logic clk;
	logic rstn;
	logic p0_sel;
	logic p0_enable;
	logic p0_write;
	plat_ctrl_pkg::addr_t p0_addr;
	plat_ctrl_pkg::word_t p0_wdata;
	plat_ctrl_pkg::word_t p0_rdata;
	logic p0_ready;
	logic p0_slverr;
	logic p1_sel;
	logic p1_enable;
	logic p1_write;
	plat_ctrl_pkg::addr_t p1_addr;
	plat_ctrl_pkg::word_t p1_wdata;
	plat_ctrl_pkg::word_t p1_rdata;
	logic p1_ready;
	logic p1_slverr;
	plat_ctrl_pkg::boot_mode_t boot_mode;
	plat_ctrl_pkg::word_t [plat_ctrl_pkg::NUM_CORES-1:0] core_pc;
	logic all_done;

	int cycle;
	int error_count;
	int check_count;
	int tests_run;
	int tests_failed;
	int test_errors_at;
	string test_name;
	logic [31:0] rng_state;

	plat_ctrl_top uut
	(
		.rvx_port_19 (clk),
		.rvx_port_18 (rstn),
		.i_p0_sel    (p0_sel),
		.i_p0_enable (p0_enable),
		.i_p0_addr   (p0_addr),
		.i_p0_write  (p0_write),
		.i_p0_wdata  (p0_wdata),
		.o_p0_rdata  (p0_rdata),
		.o_p0_ready  (p0_ready),
		.o_p0_slverr (p0_slverr),
		.i_p1_sel    (p1_sel),
		.i_p1_enable (p1_enable),
		.i_p1_addr   (p1_addr),
		.i_p1_write  (p1_write),
		.i_p1_wdata  (p1_wdata),
		.o_p1_rdata  (p1_rdata),
		.o_p1_ready  (p1_ready),
		.o_p1_slverr (p1_slverr),
		.i_boot_mode (boot_mode),
		.i_core_pc   (core_pc),
		.o_all_done  (all_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Run limit, counted in clock cycles
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ******************************************************************
	// Helpers
	// ******************************************************************

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(input string label, input logic [31:0] exp,
			input logic [31:0] act);
		check_count++;
		assert (act === exp)
		else
		begin
			$display("FAIL %s / %s: expected 0x%08h, actual 0x%08h", test_name, label, exp, act);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_at = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count == test_errors_at)
			$display("test %s: ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, error_count - test_errors_at);
		end
	endtask

	task automatic drive_port(input int port, input logic s, input logic e, input logic w,
			input plat_ctrl_pkg::addr_t a, input plat_ctrl_pkg::word_t d);
		if (port == 0)
		begin
			p0_sel    <= s;
			p0_enable <= e;
			p0_write  <= w;
			p0_addr   <= a;
			p0_wdata  <= d;
		end
		else
		begin
			p1_sel    <= s;
			p1_enable <= e;
			p1_write  <= w;
			p1_addr   <= a;
			p1_wdata  <= d;
		end
	endtask

	// Setup cycle, then access phase held until ready is seen at an edge
	task automatic bus_access(input int port, input logic wr, input plat_ctrl_pkg::addr_t a,
			input plat_ctrl_pkg::word_t d, output plat_ctrl_pkg::word_t rd,
			output logic err, output int waits, output int done_at);
		logic rdy;
		rdy = 1'b0;
		waits = 0;
		done_at = 0;
		rd = '0;
		err = 1'b0;
		@(posedge clk);
		drive_port(port, 1'b1, 1'b0, wr, a, d);
		@(posedge clk);
		drive_port(port, 1'b1, 1'b1, wr, a, d);
		while (!rdy && waits <= WAIT_LIMIT)
		begin
			@(posedge clk);
			rdy = (port == 0) ? p0_ready : p1_ready;
			if (rdy)
			begin
				rd = (port == 0) ? p0_rdata : p1_rdata;
				err = (port == 0) ? p0_slverr : p1_slverr;
				done_at = cycle;
			end
			else
				waits++;
		end
		drive_port(port, 1'b0, 1'b0, 1'b0, '0, '0);
		if (!rdy)
		begin
			$display("Port %0d hung: ready never rose for the access at 0x%02h", port, a);
			error_count++;
		end
	endtask

	task automatic expect_read(input int port, input plat_ctrl_pkg::addr_t a,
			input plat_ctrl_pkg::word_t exp, input string label);
		plat_ctrl_pkg::word_t rd;
		logic err;
		int waits;
		int done_at;
		bus_access(port, 1'b0, a, '0, rd, err, waits, done_at);
		check_value(label, exp, rd);
		check_value({label, " slverr"}, 32'(1'b0), 32'(err));
	endtask

	// Error accesses must also return zero data
	task automatic write_reg(input int port, input plat_ctrl_pkg::addr_t a,
			input logic exp_err, input string label);
		plat_ctrl_pkg::word_t rd;
		logic err;
		int waits;
		int done_at;
		bus_access(port, 1'b1, a, xorshift32(), rd, err, waits, done_at);
		check_value({label, " slverr"}, 32'(exp_err), 32'(err));
		check_value({label, " rdata"}, '0, rd);
	endtask

	// ******************************************************************
	// Tests
	// ******************************************************************

	task automatic check_reset_state();
		start_test("reset_state");
		@(posedge clk);
		check_value("p0 ready", 32'(1'b0), 32'(p0_ready));
		check_value("p1 ready", 32'(1'b0), 32'(p1_ready));
		check_value("all_done", 32'(1'b0), 32'(all_done));
		expect_read(0, plat_ctrl_pkg::REG_BOOT_STATUS,
			32'(plat_ctrl_pkg::BOOT_RESETED), "status");
		expect_read(1, plat_ctrl_pkg::REG_FINISH_COUNT, '0, "count");
		end_test();
	endtask

	task automatic run_boot_sequence();
		start_test("boot_sequence");
		write_reg(0, plat_ctrl_pkg::REG_ALL_READY, 1'b0, "early all_ready");
		expect_read(0, plat_ctrl_pkg::REG_BOOT_STATUS,
			32'(plat_ctrl_pkg::BOOT_RESETED), "still reset");
		write_reg(0, plat_ctrl_pkg::REG_APP_LOADED, 1'b0, "app_loaded");
		expect_read(0, plat_ctrl_pkg::REG_BOOT_STATUS,
			32'(plat_ctrl_pkg::BOOT_APP_LOAD), "app load");
		write_reg(1, plat_ctrl_pkg::REG_ALL_READY, 1'b0, "all_ready");
		expect_read(0, plat_ctrl_pkg::REG_BOOT_STATUS,
			32'(plat_ctrl_pkg::BOOT_ALL_READY), "ready");
		write_reg(0, plat_ctrl_pkg::REG_APP_LOADED, 1'b0, "late app_loaded");
		expect_read(1, plat_ctrl_pkg::REG_BOOT_STATUS,
			32'(plat_ctrl_pkg::BOOT_ALL_READY), "final");
		end_test();
	endtask

	task automatic count_core_finishes();
		start_test("finish_count");
		for (int k = 1; k <= DONE_COUNT + 1; k++)
		begin
			write_reg(k % 2, plat_ctrl_pkg::REG_CORE_DONE, 1'b0, "core_done");
			expect_read(0, plat_ctrl_pkg::REG_FINISH_COUNT, 32'(k), "count");
			check_value("all_done level", 32'(k == DONE_COUNT), 32'(all_done));
		end
		end_test();
	endtask

	task automatic read_back_inputs();
		logic [31:0] r;
		plat_ctrl_pkg::boot_mode_t mode;
		plat_ctrl_pkg::word_t [plat_ctrl_pkg::NUM_CORES-1:0] pcs;
		plat_ctrl_pkg::word_t exp;
		start_test("input_readback");
		r = xorshift32();
		mode = r[1:0];
		for (int i = 0; i < plat_ctrl_pkg::NUM_CORES; i++)
			pcs[i] = xorshift32();
		@(posedge clk);
		boot_mode <= mode;
		core_pc <= pcs;
		// Inputs pass two synchronizer stages
		repeat (4) @(posedge clk);
		expect_read(0, plat_ctrl_pkg::REG_BOOT_MODE, 32'(mode), "boot mode");
		for (int i = 0; i < plat_ctrl_pkg::MAX_CORE_SLOTS; i++)
		begin
			exp = (i < plat_ctrl_pkg::NUM_CORES) ? pcs[i] : 32'hFFFF_FFFF;
			expect_read(1, plat_ctrl_pkg::REG_CORE_PC_BASE + 8'(4 * i), exp,
				$sformatf("pc slot %0d", i));
		end
		end_test();
	endtask

	task automatic check_errors_and_halt();
		plat_ctrl_pkg::word_t rd;
		logic err;
		int waits;
		int done_at;
		start_test("errors_halt");
		bus_access(0, 1'b0, 8'h40, '0, rd, err, waits, done_at);
		check_value("unmapped slverr", 32'(1'b1), 32'(err));
		check_value("unmapped rdata", '0, rd);
		write_reg(0, plat_ctrl_pkg::REG_FINISH_COUNT, 1'b1, "count write");
		expect_read(0, plat_ctrl_pkg::REG_FINISH_COUNT, 32'(DONE_COUNT + 1), "count kept");
		bus_access(1, 1'b0, plat_ctrl_pkg::REG_CORE_DONE, '0, rd, err, waits, done_at);
		check_value("event read slverr", 32'(1'b1), 32'(err));
		check_value("event read rdata", '0, rd);
		expect_read(0, plat_ctrl_pkg::REG_HALT, '0, "halt before");
		write_reg(1, plat_ctrl_pkg::REG_HALT, 1'b0, "halt write");
		expect_read(0, plat_ctrl_pkg::REG_HALT, 32'd1, "halt set");
		// A zero write must not clear the flag
		bus_access(0, 1'b1, plat_ctrl_pkg::REG_HALT, '0, rd, err, waits, done_at);
		check_value("halt zero write slverr", 32'(1'b0), 32'(err));
		expect_read(1, plat_ctrl_pkg::REG_HALT, 32'd1, "halt sticky");
		end_test();
	endtask

	task automatic contend_ports();
		plat_ctrl_pkg::word_t rd0;
		plat_ctrl_pkg::word_t rd1;
		logic err0;
		logic err1;
		int waits0;
		int waits1;
		int done0;
		int done1;
		start_test("contention");
		fork
			bus_access(0, 1'b0, plat_ctrl_pkg::REG_BOOT_STATUS, '0, rd0, err0, waits0, done0);
			bus_access(1, 1'b0, plat_ctrl_pkg::REG_FINISH_COUNT, '0, rd1, err1, waits1, done1);
		join
		check_value("p0 data", 32'(plat_ctrl_pkg::BOOT_ALL_READY), rd0);
		check_value("p1 data", 32'(DONE_COUNT + 1), rd1);
		check_value("p0 slverr", 32'(1'b0), 32'(err0));
		check_value("p1 slverr", 32'(1'b0), 32'(err1));
		check_value("p1 ready after p0", 32'(1'b1), 32'(done1 > done0));
		// Lone access must not wait
		bus_access(1, 1'b0, plat_ctrl_pkg::REG_HALT, '0, rd1, err1, waits1, done1);
		check_value("lone p1 data", 32'd1, rd1);
		check_value("lone p1 waits", 32'd0, 32'(waits1));
		end_test();
	endtask

	initial
	begin
		rstn = 1'b0;
		p0_sel = 1'b0;
		p0_enable = 1'b0;
		p0_write = 1'b0;
		p0_addr = '0;
		p0_wdata = '0;
		p1_sel = 1'b0;
		p1_enable = 1'b0;
		p1_write = 1'b0;
		p1_addr = '0;
		p1_wdata = '0;
		boot_mode = '0;
		core_pc = '0;
		cycle = 0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		rng_state = 32'd78;
		repeat (16) @(posedge clk);
		rstn <= 1'b1;
		check_reset_state();
		run_boot_sequence();
		count_core_finishes();
		read_back_inputs();
		check_errors_and_halt();
		contend_ports();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
